/* hw/id_defs.svh */
// ID stage shared constants
// Data and register index widths, RV32I major opcodes, link increment

`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

`define ID_XLEN       32
`define ID_REG_AW     5

// Major opcodes, instr[6:0]
`define ID_OPC_LOAD   7'h03
`define ID_OPC_OP_IMM 7'h13
`define ID_OPC_AUIPC  7'h17
`define ID_OPC_STORE  7'h23
`define ID_OPC_OP     7'h33
`define ID_OPC_LUI    7'h37
`define ID_OPC_BRANCH 7'h63
`define ID_OPC_JALR   7'h67
`define ID_OPC_JAL    7'h6f

// Return address offset for JAL/JALR
`define ID_PC_INCR    4

`endif

/* hw/id_pkg.sv */
// ID stage types
// Vector typedefs, control enums and the bundles passed between the decode blocks

`include "id_defs.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]   word_t;
  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // ALU operator, compare codes double as branch condition
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] { OP_A_REG_A, OP_A_CURRPC, OP_A_IMM_ZERO } op_a_sel_e;
  typedef enum logic { OP_B_REG_B, OP_B_IMM } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Class that steers the FSM
  typedef enum logic [2:0] {
    CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_LSU, CLS_ILLEGAL
  } insn_class_e;

  typedef enum logic { FIRST_CYCLE, MULTI_CYCLE } id_fsm_e;

  // Decoder output bundle
  typedef struct packed {
    insn_class_e cls;
    alu_op_e     alu_op;
    op_a_sel_e   op_a_sel;
    op_b_sel_e   op_b_sel;
    imm_b_sel_e  imm_b_sel;
    logic        rf_we;
    logic        ren_a;
    logic        ren_b;
    logic        lsu_we;
    logic [1:0]  lsu_type;    // 00 word, 01 half, 10 byte
    logic        lsu_sign_ext;
  } dec_ctrl_t;

  typedef struct packed {
    word_t i;
    word_t s;
    word_t b;
    word_t u;
    word_t j;
  } imm_set_t;

  typedef struct packed {
    alu_op_e alu_op;
    word_t   op_a;
    word_t   op_b;
  } ex_req_t;

  // Request towards the load/store unit
  typedef struct packed {
    logic       req;
    logic       we;
    logic [1:0] data_type;
    logic       sign_ext;
    word_t      wdata;
  } lsu_req_t;

endpackage

/* hw/id_decoder.sv */
// RV32I instruction decoder
// Opcode/funct decoding into the control bundle and extraction of the immediates

`timescale 1ns/100ps
`include "id_defs.svh"

module id_decoder (
  input  id_pkg::word_t     instr_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::imm_set_t  imm_o,
  output id_pkg::reg_addr_t raddr_a_o,
  output id_pkg::reg_addr_t raddr_b_o,
  output id_pkg::reg_addr_t waddr_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [1:0] lsu_size;
  logic       lsu_size_ok;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Fixed register fields
  assign raddr_a_o = instr_i[19:15];
  assign raddr_b_o = instr_i[24:20];
  assign waddr_o   = instr_i[11:7];

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign imm_o.i = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_o.s = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // B and J are halfword aligned, bit 0 forced low
  assign imm_o.b = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
  assign imm_o.u = {instr_i[31:12], 12'b0};
  assign imm_o.j = {{(`ID_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

  // Access size from funct3[1:0], shared by loads and stores
  always_comb begin
    lsu_size_ok = 1'b1;
    case (funct3[1:0])
      2'b00:   lsu_size = 2'b10;
      2'b01:   lsu_size = 2'b01;
      2'b10:   lsu_size = 2'b00;
      default: begin
        lsu_size    = 2'b00;
        lsu_size_ok = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults describe a register-register ALU op with nothing enabled
    ctrl_o           = '0;
    ctrl_o.cls       = CLS_ALU;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.op_a_sel  = OP_A_REG_A;
    ctrl_o.op_b_sel  = OP_B_REG_B;
    ctrl_o.imm_b_sel = IMM_B_I;
    illegal          = 1'b0;

    case (opcode)
      `ID_OPC_LUI: begin
        ctrl_o.op_a_sel  = OP_A_IMM_ZERO;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end
      `ID_OPC_AUIPC: begin
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end
      `ID_OPC_JAL: begin
        ctrl_o.cls       = CLS_JUMP;
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_J;
        ctrl_o.rf_we     = 1'b1;
      end
      `ID_OPC_JALR: begin
        ctrl_o.cls       = CLS_JUMP;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.ren_a     = 1'b1;
        illegal          = (funct3 != 3'b000);
      end
      `ID_OPC_BRANCH: begin
        // Operands form the target, operator carries the condition
        ctrl_o.cls       = CLS_BRANCH;
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_B;
        ctrl_o.ren_a     = 1'b1;
        ctrl_o.ren_b     = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      `ID_OPC_LOAD: begin
        ctrl_o.cls          = CLS_LSU;
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.ren_a        = 1'b1;
        ctrl_o.lsu_type     = lsu_size;
        ctrl_o.lsu_sign_ext = ~funct3[2];
        // LWU does not exist on RV32
        illegal             = ~lsu_size_ok | (funct3 == 3'b110);
      end
      `ID_OPC_STORE: begin
        ctrl_o.cls       = CLS_LSU;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_S;
        ctrl_o.ren_a     = 1'b1;
        ctrl_o.ren_b     = 1'b1;
        ctrl_o.lsu_we    = 1'b1;
        ctrl_o.lsu_type  = lsu_size;
        illegal          = ~lsu_size_ok | funct3[2];
      end
      `ID_OPC_OP_IMM: begin
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.ren_a    = 1'b1;
        case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op = ALU_SLL;
            illegal       = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal       = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      `ID_OPC_OP: begin
        ctrl_o.rf_we = 1'b1;
        ctrl_o.ren_a = 1'b1;
        ctrl_o.ren_b = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Unknown encodings leave every enable low
    if (illegal) begin
      ctrl_o     = '0;
      ctrl_o.cls = CLS_ILLEGAL;
    end
  end

endmodule

/* hw/id_operand_mux.sv */
// ALU operand selection
// Picks immediate B, then operand A and operand B for the execute request

`timescale 1ns/100ps
`include "id_defs.svh"

module id_operand_mux (
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::imm_set_t  imm_i,
  input  logic              first_cycle_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::word_t     rdata_a_i,
  input  id_pkg::word_t     rdata_b_i,
  output id_pkg::ex_req_t   ex_o
);

  import id_pkg::*;

  logic       jump_link;
  op_a_sel_e  op_a_sel;
  imm_b_sel_e imm_b_sel;
  word_t      imm_b;

  // Second cycle of a jump computes the link address PC + 4
  assign jump_link = (ctrl_i.cls == CLS_JUMP) & ~first_cycle_i;
  assign op_a_sel  = jump_link ? OP_A_CURRPC   : ctrl_i.op_a_sel;
  assign imm_b_sel = jump_link ? IMM_B_INCR_PC : ctrl_i.imm_b_sel;

  always_comb begin
    case (imm_b_sel)
      IMM_B_I:       imm_b = imm_i.i;
      IMM_B_S:       imm_b = imm_i.s;
      IMM_B_B:       imm_b = imm_i.b;
      IMM_B_U:       imm_b = imm_i.u;
      IMM_B_J:       imm_b = imm_i.j;
      default:       imm_b = word_t'(`ID_PC_INCR);
    endcase
  end

  // Operand A, zero source serves LUI
  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  ex_o.op_a = rdata_a_i;
      OP_A_CURRPC: ex_o.op_a = pc_i;
      default:     ex_o.op_a = {`ID_XLEN{1'b0}};
    endcase
  end

  assign ex_o.op_b   = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;
  assign ex_o.alu_op = ctrl_i.alu_op;

endmodule

/* hw/id_fsm.sv */
// ID stage control FSM
// First/multi-cycle sequencing, stalls, branch/jump set and done generation

`timescale 1ns/100ps

module id_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  id_pkg::insn_class_e cls_i,
  input  logic                rf_we_dec_i,
  input  logic                branch_decision_i,
  input  logic                lsu_resp_valid_i,
  output logic                first_cycle_o,
  output logic                rf_we_o,
  output logic                pc_set_o,
  output logic                lsu_req_o,
  output logic                done_o
);

  import id_pkg::*;

  id_fsm_e state_q, state_d;
  logic    is_lsu;
  logic    stall_mem, stall_branch, stall_jump;
  logic    branch_set_d, branch_set_q;
  logic    jump_set;
  logic    set_done_q;
  logic    rf_we_raw;

  assign is_lsu        = (cls_i == CLS_LSU);
  assign first_cycle_o = valid_i & (state_q == FIRST_CYCLE);

  // Memory ops stall the first cycle, then until the response pulse
  assign stall_mem = valid_i & is_lsu & (~lsu_resp_valid_i | first_cycle_o);
  assign lsu_req_o = first_cycle_o & is_lsu;

  ////////////////////////////////////////////////////////////
  // Next state and stalls
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    rf_we_raw    = rf_we_dec_i;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;

    if (valid_i) begin
      case (state_q)
        FIRST_CYCLE: begin
          case (cls_i)
            CLS_LSU: state_d = MULTI_CYCLE;
            CLS_BRANCH: begin
              // Only taken branches need the second cycle
              state_d      = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
              stall_branch = branch_decision_i;
              branch_set_d = branch_decision_i;
            end
            CLS_JUMP: begin
              // Target goes out now, link write follows next cycle
              state_d    = MULTI_CYCLE;
              stall_jump = 1'b1;
              jump_set   = 1'b1;
              rf_we_raw  = 1'b0;
            end
            CLS_ILLEGAL: rf_we_raw = 1'b0;
            default:     state_d = FIRST_CYCLE;
          endcase
        end
        default: begin
          // Branch and jump finish here, memory waits for its response
          if (!is_lsu || lsu_resp_valid_i) begin
            state_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  assign done_o  = valid_i & ~(stall_mem | stall_branch | stall_jump);
  assign rf_we_o = valid_i & rf_we_raw;

  // One PC set per instruction, flag cleared once it is done
  assign pc_set_o = (branch_set_q | jump_set) & ~set_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      if (valid_i) begin
        state_q <= state_d;
      end
      branch_set_q <= branch_set_d;
      set_done_q   <= (branch_set_q | jump_set | set_done_q) & ~done_o;
    end
  end

endmodule

/* hw/id_stage.sv */
// RV32I instruction decode stage
// Decoder, operand selection and control FSM, drives execute and LSU requests

`timescale 1ns/100ps

module id_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  id_pkg::word_t     instr_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::word_t     rf_rdata_a_i,
  input  id_pkg::word_t     rf_rdata_b_i,
  input  logic              branch_decision_i,
  input  logic              lsu_resp_valid_i,
  output id_pkg::ex_req_t   ex_o,
  output id_pkg::lsu_req_t  lsu_o,
  output id_pkg::reg_addr_t rf_raddr_a_o,
  output id_pkg::reg_addr_t rf_raddr_b_o,
  output id_pkg::reg_addr_t rf_waddr_o,
  output logic              rf_we_o,
  output logic              rf_ren_a_o,
  output logic              rf_ren_b_o,
  output logic              illegal_insn_o,
  output logic              pc_set_o,
  output logic              instr_done_o,
  output logic              instr_first_cycle_o
);

  import id_pkg::*;

  dec_ctrl_t ctrl;
  imm_set_t  imm;
  logic      first_cycle;
  logic      lsu_req;

  id_decoder u_decoder (
    .instr_i  (instr_i),
    .ctrl_o   (ctrl),
    .imm_o    (imm),
    .raddr_a_o(rf_raddr_a_o),
    .raddr_b_o(rf_raddr_b_o),
    .waddr_o  (rf_waddr_o)
  );

  id_operand_mux u_operand_mux (
    .ctrl_i       (ctrl),
    .imm_i        (imm),
    .first_cycle_i(first_cycle),
    .pc_i         (pc_i),
    .rdata_a_i    (rf_rdata_a_i),
    .rdata_b_i    (rf_rdata_b_i),
    .ex_o         (ex_o)
  );

  id_fsm u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (instr_valid_i),
    .cls_i            (ctrl.cls),
    .rf_we_dec_i      (ctrl.rf_we),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .rf_we_o          (rf_we_o),
    .pc_set_o         (pc_set_o),
    .lsu_req_o        (lsu_req),
    .done_o           (instr_done_o)
  );

  ////////////////////////////////////////////////////////////
  // Output gating
  ////////////////////////////////////////////////////////////

  assign illegal_insn_o      = instr_valid_i & (ctrl.cls == CLS_ILLEGAL);
  assign instr_first_cycle_o = first_cycle;

  // Read ports only for valid, legal instructions
  assign rf_ren_a_o = instr_valid_i & ~illegal_insn_o & ctrl.ren_a;
  assign rf_ren_b_o = instr_valid_i & ~illegal_insn_o & ctrl.ren_b;

  // Store data straight from rs2, no forwarding
  assign lsu_o.req       = lsu_req;
  assign lsu_o.we        = ctrl.lsu_we;
  assign lsu_o.data_type = ctrl.lsu_type;
  assign lsu_o.sign_ext  = ctrl.lsu_sign_ext;
  assign lsu_o.wdata     = rf_rdata_b_i;

endmodule

/* tb/id_checker.sv */
// ID stage checker
// Watches the DUT ports each cycle and compares them with the current case

`timescale 1ns/100ps

module id_checker (
  input  logic              clk_i,
  input  logic [235:0]      case_i,
  input  logic              instr_valid_i,
  input  id_pkg::ex_req_t   ex_i,
  input  id_pkg::lsu_req_t  lsu_i,
  input  id_pkg::reg_addr_t rf_raddr_a_i,
  input  id_pkg::reg_addr_t rf_raddr_b_i,
  input  id_pkg::reg_addr_t rf_waddr_i,
  input  logic              rf_we_i,
  input  logic              rf_ren_a_i,
  input  logic              rf_ren_b_i,
  input  logic              illegal_i,
  input  logic              pc_set_i,
  input  logic              done_i,
  input  logic              first_cycle_i,
  output int                err_cnt_o,
  output int                done_cnt_o
);

  import id_pkg::*;

  localparam logic [3:0] K_JUMP   = 4'd2;
  localparam logic [3:0] K_LOAD   = 4'd3;
  localparam logic [3:0] K_STORE  = 4'd4;
  localparam logic [3:0] K_ILL    = 4'd5;

  logic [3:0]  cyc;
  logic [7:0]  id;
  logic [31:0] instr, pc, rdata_b, exp_a, exp_b;
  logic [3:0]  kind, exp_alu, exp_pcset, exp_done;
  logic [7:0]  exp_waddr;
  logic        exp_we, is_mem;
  logic [67:0] ex_snap;
  logic [35:0] lsu_snap;

  initial begin
    err_cnt_o  = 0;
    done_cnt_o = 0;
    cyc        = '0;
  end

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAILED case %0d %s: expected %h, actual %h", id, name, exp_v, act_v);
      err_cnt_o = err_cnt_o + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle comparison at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!instr_valid_i) begin
      cyc = '0;
    end else begin
      cyc = cyc + 4'd1;
      if (cyc == 4'd1) begin
        // Unpack the case that was applied with this instruction
        id        = case_i[235:228];
        instr     = case_i[227:196];
        pc        = case_i[195:164];
        rdata_b   = case_i[131:100];
        kind      = case_i[91:88];
        exp_alu   = case_i[87:84];
        exp_a     = case_i[83:52];
        exp_b     = case_i[51:20];
        exp_waddr = case_i[19:12];
        exp_we    = case_i[8];
        exp_pcset = case_i[7:4];
        exp_done  = case_i[3:0];
        is_mem    = (kind == K_LOAD) || (kind == K_STORE);
        ex_snap   = ex_i;
        lsu_snap  = lsu_i[35:0];
        if (kind != K_ILL) begin
          check_field("alu_op", 32'(exp_alu), 32'(ex_i.alu_op));
          check_field("op_a", exp_a, ex_i.op_a);
          check_field("op_b", exp_b, ex_i.op_b);
        end
        // Source register fields sit at the same place in every RV32I format
        check_field("raddr_a", 32'(instr[19:15]), 32'(rf_raddr_a_i));
        check_field("raddr_b", 32'(instr[24:20]), 32'(rf_raddr_b_i));
        check_field("waddr", 32'(exp_waddr), 32'(rf_waddr_i));
        check_field("lsu_req", 32'(is_mem), 32'(lsu_i.req));
        if (kind == K_STORE) begin
          check_field("lsu_we", 32'd1, 32'(lsu_i.we));
          check_field("lsu_wdata", rdata_b, lsu_i.wdata);
        end
        if (kind == K_LOAD) begin
          check_field("lsu_we", 32'd0, 32'(lsu_i.we));
        end
        // Link write is held back while the jump target goes out
        if (kind == K_JUMP) begin
          check_field("jump_first_rf_we", 32'd0, 32'(rf_we_i));
        end
      end else if (is_mem) begin
        check_field("lsu_req_late", 32'd0, 32'(lsu_i.req));
        if ({ex_i, lsu_i[35:0]} !== {ex_snap, lsu_snap}) begin
          $display("FAILED case %0d stall_stable: expected %h, actual %h",
                   id, {ex_snap, lsu_snap}, {ex_i, lsu_i[35:0]});
          err_cnt_o = err_cnt_o + 1;
        end
      end

      check_field("first_cycle", 32'(cyc == 4'd1), 32'(first_cycle_i));
      check_field("pc_set", 32'(cyc == exp_pcset), 32'(pc_set_i));
      check_field("done", 32'(cyc == exp_done), 32'(done_i));
      check_field("illegal", 32'(kind == K_ILL), 32'(illegal_i));

      if (kind == K_ILL) begin
        check_field("ren_a", 32'd0, 32'(rf_ren_a_i));
        check_field("ren_b", 32'd0, 32'(rf_ren_b_i));
        check_field("rf_we", 32'd0, 32'(rf_we_i));
      end

      if (done_i) begin
        check_field("done_rf_we", 32'(exp_we), 32'(rf_we_i));
        // Jump second cycle forms the return address
        if (kind == K_JUMP) begin
          check_field("link_op_a", pc, ex_i.op_a);
          check_field("link_op_b", 32'd4, ex_i.op_b);
        end
        done_cnt_o = done_cnt_o + 1;
      end
    end
  end

endmodule

/* tb/tb_id_stage.sv */
// ID stage testbench
// Case-file stimulus, memory responder, random idle gaps and watchdog

`timescale 1ns/100ps

module tb_id_stage;

  import id_pkg::*;

  localparam int NUM_CASES = 15;
  localparam int WATCHDOG_CYCLES = NUM_CASES * 12 + 50;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         instr_valid;
  word_t        instr, pc, rdata_a, rdata_b;
  logic         branch_decision;
  logic         lsu_resp_valid;
  logic [235:0] cur_case;
  logic [235:0] cases [0:NUM_CASES-1];

  ex_req_t   ex;
  lsu_req_t  lsu;
  reg_addr_t raddr_a, raddr_b, waddr;
  logic      rf_we, ren_a, ren_b, illegal, pc_set, done, first_cycle;
  int        err_cnt, done_cnt;

  always #2 clk = ~clk;

  id_stage uut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .instr_valid_i      (instr_valid),
    .instr_i            (instr),
    .pc_i               (pc),
    .rf_rdata_a_i       (rdata_a),
    .rf_rdata_b_i       (rdata_b),
    .branch_decision_i  (branch_decision),
    .lsu_resp_valid_i   (lsu_resp_valid),
    .ex_o               (ex),
    .lsu_o              (lsu),
    .rf_raddr_a_o       (raddr_a),
    .rf_raddr_b_o       (raddr_b),
    .rf_waddr_o         (waddr),
    .rf_we_o            (rf_we),
    .rf_ren_a_o         (ren_a),
    .rf_ren_b_o         (ren_b),
    .illegal_insn_o     (illegal),
    .pc_set_o           (pc_set),
    .instr_done_o       (done),
    .instr_first_cycle_o(first_cycle)
  );

  id_checker u_checker (
    .clk_i        (clk),
    .case_i       (cur_case),
    .instr_valid_i(instr_valid),
    .ex_i         (ex),
    .lsu_i        (lsu),
    .rf_raddr_a_i (raddr_a),
    .rf_raddr_b_i (raddr_b),
    .rf_waddr_i   (waddr),
    .rf_we_i      (rf_we),
    .rf_ren_a_i   (ren_a),
    .rf_ren_b_i   (ren_b),
    .illegal_i    (illegal),
    .pc_set_i     (pc_set),
    .done_i       (done),
    .first_cycle_i(first_cycle),
    .err_cnt_o    (err_cnt),
    .done_cnt_o   (done_cnt)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Apply one case, answer its memory access, wait for done
  task automatic run_case(input int idx);
    logic [235:0] c;
    int           cyc;
    int           delay;
    logic         is_mem;
    c      = cases[idx];
    delay  = int'(c[95:92]);
    is_mem = (c[91:88] == 4'd3) || (c[91:88] == 4'd4);
    @(posedge clk);
    cur_case        <= c;
    instr_valid     <= 1'b1;
    instr           <= c[227:196];
    pc              <= c[195:164];
    rdata_a         <= c[163:132];
    rdata_b         <= c[131:100];
    branch_decision <= c[96];
    cyc = 1;
    @(negedge clk);
    while (!done) begin
      @(posedge clk);
      cyc = cyc + 1;
      // Single-cycle response pulse with the delay counted from the request cycle
      lsu_resp_valid <= is_mem && (cyc == delay + 1);
      @(negedge clk);
    end
    @(posedge clk);
    instr_valid    <= 1'b0;
    lsu_resp_valid <= 1'b0;
  endtask

  initial begin
    int idle;
    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    instr           = '0;
    pc              = '0;
    rdata_a         = '0;
    rdata_b         = '0;
    branch_decision = 1'b0;
    lsu_resp_valid  = 1'b0;
    cur_case        = '0;
    void'($urandom(32'h022761ca));
    $readmemh("tb/id_cases.mem", cases);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_CASES; i++) begin
      idle = int'($urandom % 4);
      repeat (idle) @(posedge clk);
      run_case(i);
    end
    repeat (3) @(posedge clk);

    $display("Errors: %0d, cases done: %0d of %0d", err_cnt, done_cnt, NUM_CASES);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the number of cases
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* src.f */
+incdir+hw
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_fsm.sv
hw/id_stage.sv
tb/id_checker.sv
tb/tb_id_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_id_stage
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) hw/id_defs.svh tb/id_cases.mem

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tb/id_cases.mem */
// id instr pc rdata_a rdata_b branch delay kind alu op_a op_b waddr rf_we pc_set_cyc done_cyc
// kind: 0 alu, 1 branch, 2 jump, 3 load, 4 store, 5 illegal; pc_set_cyc 0 means never
01_002081b3_00001000_11111111_22222222_0_0_0_0_11111111_22222222_03_1_0_1
02_407302b3_00001004_00000050_00000010_0_0_0_1_00000050_00000010_05_1_0_1
03_ffb58513_00001008_00000100_deadbeef_0_0_0_0_00000100_fffffffb_0a_1_0_1
04_06413093_0000100c_00000063_00000000_0_0_0_9_00000063_00000064_01_1_0_1
05_12345237_00001010_aaaaaaaa_bbbbbbbb_0_0_0_0_00000000_12345000_04_1_0_1
06_fffff317_00002000_00000000_00000000_0_0_0_0_00002000_fffff000_06_1_0_1
07_0020a423_00002004_00003000_cafef00d_0_2_4_0_00003000_00000008_08_0_0_3
08_00208863_00003000_00000001_00000001_1_0_1_a_00003000_00000010_10_0_2_2
09_fe419ce3_00003100_00000007_00000007_0_0_1_b_00003100_fffffff8_19_0_0_1
0a_100000ef_00004000_00000000_00000000_0_0_2_0_00004000_00000100_01_1_1_2
0b_00c302e7_00004100_00005000_00000000_0_0_2_0_00005000_0000000c_05_1_1_2
0c_00412383_00004200_00006000_12345678_0_1_3_0_00006000_00000004_07_1_0_2
0d_fff48403_00004204_00007000_00000000_0_3_3_0_00007000_ffffffff_08_1_0_4
0e_0026d603_00004208_00008000_00000000_0_5_3_0_00008000_00000002_0c_1_0_6
0f_ffffffff_00004300_00000000_00000000_0_0_5_0_00000000_00000000_1f_0_0_1
